// ==== logic/sv32_consts.svh ====
`ifndef SV32_CONSTS_SVH
`define SV32_CONSTS_SVH

// page geometry
`define PAGE_SHIFT 12
`define PTE_SHIFT 2

// field widths of the virtual address and of a page table entry
`define VPN_W 10
`define PPN_W 22

// synchronous exception causes reported on err_code
`define CAUSE_LOAD_ACCESS 16'd5
`define CAUSE_STORE_ACCESS 16'd7
`define CAUSE_LOAD_PAGE 16'd13
`define CAUSE_STORE_PAGE 16'd15

`endif

// ==== logic/sv32_pkg.sv ====
`default_nettype none
`include "sv32_consts.svh"

package sv32_pkg;

	// Sv32 page table entry, flag bits from lsb upward
	typedef struct packed {
		logic [`PPN_W-1:0] ppn;
		logic [1:0] rsw;
		logic d;
		logic a;
		logic g;
		logic u;
		logic x;
		logic w;
		logic r;
		logic v;
	} pte_t;

	// one bus read word, seen as an entry during the walk
	// and as plain data when it goes back to the processor
	typedef union packed {
		logic [31:0] data;
		pte_t pte;
	} mem_word_u;

	typedef enum logic [2:0] {
		WALK_IDLE,
		WALK_LV1_READ,
		WALK_LV1_CHECK,
		WALK_LV2_READ,
		WALK_LV2_CHECK,
		WALK_DATA_ACCESS,
		WALK_FAULT
	} walk_state_e;

endpackage

`default_nettype wire

// ==== logic/mem_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if ();

	// request side
	logic req;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic we;
	logic rd;

	// arbitration and response side
	logic gnt;
	logic hrd;
	sv32_pkg::mem_word_u rdata;
	logic ready;

	modport master (
		output req,
		output addr,
		output wdata,
		output we,
		output rd,
		input gnt,
		input hrd,
		input rdata,
		input ready
	);

	modport slave (
		input req,
		input addr,
		input wdata,
		input we,
		input rd,
		output gnt,
		output hrd,
		output rdata,
		output ready
	);

endinterface

`default_nettype wire

// ==== logic/sv32_walker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sv32_consts.svh"

module sv32_walker (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [31:0] va,
	input logic [31:0] vd,
	input logic vwe,
	input logic vrd,
	input logic [1:0] mode,
	input logic [`PPN_W-1:0] root_ppn,
	mem_bus_if.master bus,
	output logic done,
	output logic pagefault,
	output logic accessfault,
	output logic [15:0] err_code,
	output logic [31:0] rdata
);

	sv32_pkg::walk_state_e state;
	sv32_pkg::walk_state_e state_n;

	// request captured when the walk starts
	logic [31:0] va_q;
	logic [31:0] vd_q;
	logic vwe_q;
	logic vrd_q;

	// entry of the current level, level 2 overwrites level 1
	sv32_pkg::pte_t pte_q;

	logic acc_fault_q;
	logic acc_fault_n;

	logic [`VPN_W-1:0] vpn1;
	logic [`VPN_W-1:0] vpn0;
	logic [`PAGE_SHIFT-1:0] offset;
	logic [31:0] lv1_addr;
	logic [31:0] lv2_addr;
	logic [31:0] data_addr;
	logic xfer;
	logic pte_bad;
	logic pte_leaf;
	logic perm_fail;

	assign vpn1 = va_q[31 -: `VPN_W];
	assign vpn0 = va_q[`PAGE_SHIFT +: `VPN_W];
	assign offset = va_q[`PAGE_SHIFT-1:0];

	assign lv1_addr = (32'(root_ppn) << `PAGE_SHIFT) + (32'(vpn1) << `PTE_SHIFT);
	assign lv2_addr = (32'(pte_q.ppn) << `PAGE_SHIFT) + (32'(vpn0) << `PTE_SHIFT);
	assign data_addr = (32'(pte_q.ppn) << `PAGE_SHIFT) | 32'(offset);

	assign xfer = bus.req && bus.gnt && bus.ready;

	// invalid, or the reserved W without R combination
	assign pte_bad = !pte_q.v || (pte_q.w && !pte_q.r);
	assign pte_leaf = pte_q.r || pte_q.x;
	// write to a read-only page, or user mode on a supervisor page
	assign perm_fail = (vwe_q && !pte_q.w) || (mode == 2'b00 && !pte_q.u);

	assign rdata = bus.rdata.data;

	always_comb begin
		if (vwe_q) begin
			err_code = acc_fault_q ? `CAUSE_STORE_ACCESS : `CAUSE_STORE_PAGE;
		end else begin
			err_code = acc_fault_q ? `CAUSE_LOAD_ACCESS : `CAUSE_LOAD_PAGE;
		end
	end

	always_comb begin
		state_n = state;
		acc_fault_n = acc_fault_q;
		bus.req = 1'b0;
		bus.rd = 1'b0;
		bus.we = 1'b0;
		bus.addr = 32'h0;
		bus.wdata = vd_q;
		done = 1'b0;
		pagefault = 1'b0;
		accessfault = 1'b0;
		case (state)
			sv32_pkg::WALK_IDLE: begin
				if (start) begin
					state_n = sv32_pkg::WALK_LV1_READ;
				end
			end
			sv32_pkg::WALK_LV1_READ: begin
				bus.addr = lv1_addr;
				bus.req = !bus.hrd;
				bus.rd = !bus.hrd;
				if (xfer) begin
					state_n = sv32_pkg::WALK_LV1_CHECK;
				end
			end
			sv32_pkg::WALK_LV1_CHECK: begin
				if (pte_bad) begin
					acc_fault_n = 1'b0;
					state_n = sv32_pkg::WALK_FAULT;
				end else if (pte_leaf) begin
					// superpage leaf, not supported
					acc_fault_n = 1'b1;
					state_n = sv32_pkg::WALK_FAULT;
				end else begin
					state_n = sv32_pkg::WALK_LV2_READ;
				end
			end
			sv32_pkg::WALK_LV2_READ: begin
				bus.addr = lv2_addr;
				bus.req = !bus.hrd;
				bus.rd = !bus.hrd;
				if (xfer) begin
					state_n = sv32_pkg::WALK_LV2_CHECK;
				end
			end
			sv32_pkg::WALK_LV2_CHECK: begin
				acc_fault_n = 1'b0;
				// a non-leaf at the last level is a page fault as well
				if (pte_bad || !pte_leaf || perm_fail) begin
					state_n = sv32_pkg::WALK_FAULT;
				end else begin
					state_n = sv32_pkg::WALK_DATA_ACCESS;
				end
			end
			sv32_pkg::WALK_DATA_ACCESS: begin
				bus.addr = data_addr;
				bus.req = !bus.hrd;
				bus.rd = !bus.hrd && vrd_q;
				bus.we = !bus.hrd && vwe_q;
				done = xfer;
				if (xfer) begin
					state_n = sv32_pkg::WALK_IDLE;
				end
			end
			sv32_pkg::WALK_FAULT: begin
				done = 1'b1;
				pagefault = !acc_fault_q;
				accessfault = acc_fault_q;
				state_n = sv32_pkg::WALK_IDLE;
			end
			default: begin
				state_n = sv32_pkg::WALK_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sv32_pkg::WALK_IDLE;
			acc_fault_q <= 1'b0;
		end else begin
			state <= state_n;
			acc_fault_q <= acc_fault_n;
		end
	end

	always_ff @(posedge clk) begin
		if (state == sv32_pkg::WALK_IDLE && start) begin
			va_q <= va;
			vd_q <= vd;
			vwe_q <= vwe;
			vrd_q <= vrd;
		end
		if (xfer && (state == sv32_pkg::WALK_LV1_READ || state == sv32_pkg::WALK_LV2_READ)) begin
			pte_q <= bus.rdata.pte;
		end
	end

	// the bus arbiter owns the bus while hold is up
	a_no_req_in_hold: assert property (@(posedge clk) disable iff (rst)
		!(bus.req && bus.hrd));

	// a stalled access keeps its address until it completes
	a_addr_held: assert property (@(posedge clk) disable iff (rst)
		bus.req && !(bus.gnt && bus.ready) |=> $stable(bus.addr));

endmodule

`default_nettype wire

// ==== logic/sv32_mmu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module sv32_mmu_core (
	input logic clk,
	input logic rst,
	input logic [1:0] mode,
	input logic paging,

	// processor side
	input logic vreq,
	input logic [31:0] va,
	input logic [31:0] vd,
	input logic vwe,
	input logic vrd,
	output logic vgnt,
	output logic vhrd,
	output logic [31:0] vspo,
	output logic vready,

	// physical bus side
	output logic preq,
	output logic [31:0] pa,
	output logic [31:0] pd,
	output logic pwe,
	output logic prd,
	input logic pgnt,
	input logic phrd,
	input logic [31:0] pspo,
	input logic pready,

	// walker bus and handshake
	mem_bus_if.slave walk,
	output logic start,
	input logic done
);

	logic enabled;
	logic busy;
	logic done_q;
	logic strobe;

	assign strobe = vrd || vwe;

	// translation applies in user and supervisor mode with paging on,
	// switched only between walks
	always_ff @(posedge clk) begin
		if (rst) begin
			enabled <= 1'b0;
		end else if (!busy && !start) begin
			enabled <= !mode[1] && paging;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= done;
			if (start) begin
				busy <= 1'b1;
			end else if (done) begin
				busy <= 1'b0;
			end
		end
	end

	// the strobe is still up in the cycle after vready, ignore it there
	assign start = enabled && !busy && !done_q && strobe;

	// arbitration and response from the physical bus go to the walker
	assign walk.gnt = pgnt;
	assign walk.hrd = phrd;
	assign walk.ready = pready;
	assign walk.rdata = sv32_pkg::mem_word_u'(pspo);

	always_comb begin
		if (enabled) begin
			preq = walk.req;
			pa = walk.addr;
			pd = walk.wdata;
			pwe = walk.we;
			prd = walk.rd;
			// the processor never waits on arbitration here
			vgnt = 1'b1;
			vhrd = 1'b0;
			vready = done;
			vspo = done ? walk.rdata.data : 32'h0;
		end else begin
			preq = vreq;
			pa = va;
			pd = vd;
			pwe = vwe;
			prd = vrd;
			vgnt = pgnt;
			vhrd = phrd;
			vready = pready;
			vspo = pspo;
		end
	end

	// done only comes back for a walk that has already been started
	a_start_done_apart: assert property (@(posedge clk) disable iff (rst)
		!(done && start));

endmodule

`default_nettype wire

// ==== logic/mmu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sv32_consts.svh"

module mmu_top (
	input logic clk,
	input logic rst,
	input logic [1:0] mode,
	input logic paging,
	input logic [`PPN_W-1:0] root_ppn,

	input logic vreq,
	output logic vgnt,
	output logic vhrd,
	input logic [31:0] va,
	input logic [31:0] vd,
	input logic vwe,
	input logic vrd,
	output logic [31:0] vspo,
	output logic vready,

	output logic preq,
	input logic pgnt,
	input logic phrd,
	output logic [31:0] pa,
	output logic [31:0] pd,
	output logic pwe,
	output logic prd,
	input logic [31:0] pspo,
	input logic pready,

	output logic pagefault,
	output logic accessfault,
	output logic [15:0] err_code
);

	logic start;
	logic done;

	mem_bus_if walk_bus ();

	sv32_mmu_core u_core (
		.clk(clk),
		.rst(rst),
		.mode(mode),
		.paging(paging),
		.vreq(vreq),
		.va(va),
		.vd(vd),
		.vwe(vwe),
		.vrd(vrd),
		.vgnt(vgnt),
		.vhrd(vhrd),
		.vspo(vspo),
		.vready(vready),
		.preq(preq),
		.pa(pa),
		.pd(pd),
		.pwe(pwe),
		.prd(prd),
		.pgnt(pgnt),
		.phrd(phrd),
		.pspo(pspo),
		.pready(pready),
		.walk(walk_bus.slave),
		.start(start),
		.done(done)
	);

	// read data reaches the processor through the core's vspo
	sv32_walker u_walker (
		.clk(clk),
		.rst(rst),
		.start(start),
		.va(va),
		.vd(vd),
		.vwe(vwe),
		.vrd(vrd),
		.mode(mode),
		.root_ppn(root_ppn),
		.bus(walk_bus.master),
		.done(done),
		.pagefault(pagefault),
		.accessfault(accessfault),
		.err_code(err_code),
		.rdata()
	);

endmodule

`default_nettype wire

// ==== testbench/tb_phys_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_phys_mem (
	input logic clk,
	input logic rst,
	input logic stress,
	input logic req,
	input logic [31:0] addr,
	input logic [31:0] wdata,
	input logic we,
	input logic rd,
	output logic gnt,
	output logic hrd,
	output logic [31:0] rdata,
	output logic ready
);

	// 64 KiB, word addressed
	logic [31:0] words [0:16383];
	logic [31:0] rnd;
	logic gnt_q;
	logic ready_q;
	logic hrd_q;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] pte(input logic [21:0] ppn, input logic [9:0] flags);
		return {ppn, flags};
	endfunction

	initial begin
		for (int i = 0; i < 16384; i++) begin
			words[i] = (32'(i) << 2) ^ (32'(i) << 18) ^ 32'ha5c3_5a3c;
		end
		// level 1 table at page 1
		words[14'h400] = pte(22'd2, 10'h001);
		words[14'h401] = 32'h0;
		words[14'h402] = pte(22'd7, 10'h003);
		words[14'h403] = pte(22'd2, 10'h005);
		// level 2 table at page 2
		words[14'h800] = pte(22'd4, 10'h007);
		words[14'h801] = pte(22'd5, 10'h003);
		words[14'h802] = 32'h0;
		words[14'h803] = pte(22'd4, 10'h005);
		words[14'h804] = pte(22'd3, 10'h001);
		words[14'h805] = pte(22'd6, 10'h013);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rnd <= 32'hf03e1fc9;
			gnt_q <= 1'b1;
			ready_q <= 1'b1;
			hrd_q <= 1'b0;
		end else begin
			rnd <= xorshift(rnd);
			gnt_q <= !stress || rnd[1:0] != 2'b00;
			ready_q <= !stress || rnd[3:2] != 2'b00;
			hrd_q <= stress && rnd[9:6] == 4'h0;
		end
	end

	// hold takes the bus away, so no transfer completes under it
	assign hrd = hrd_q;
	assign gnt = gnt_q && !hrd_q;
	assign ready = ready_q && !hrd_q;
	assign rdata = words[addr[15:2]];

	always @(posedge clk) begin
		if (req && gnt && ready && we) begin
			words[addr[15:2]] <= wdata;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_mmu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sv32_consts.svh"

module tb_mmu_top;

	typedef struct packed {
		logic [1:0] mode;
		logic paging;
		logic [31:0] va;
		logic wr;
		logic [31:0] wdata;
		logic [31:0] pa;
		logic pf;
		logic af;
		logic [15:0] cause;
	} case_t;

	logic clk;
	logic rst;
	logic stress;
	logic [1:0] mode;
	logic paging;
	logic [21:0] root_ppn;
	logic vreq;
	logic vgnt;
	logic vhrd;
	logic [31:0] va;
	logic [31:0] vd;
	logic vwe;
	logic vrd;
	logic [31:0] vspo;
	logic vready;
	logic preq;
	logic pgnt;
	logic phrd;
	logic [31:0] pa;
	logic [31:0] pd;
	logic pwe;
	logic prd;
	logic [31:0] pspo;
	logic pready;
	logic pagefault;
	logic accessfault;
	logic [15:0] err_code;

	case_t cases[$];
	logic [31:0] shadow[logic [31:0]];
	int errors;
	int failed;
	int run;
	logic hung;

	mmu_top dut (.*);

	tb_phys_mem mem (
		.clk(clk), .rst(rst), .stress(stress), .req(preq), .addr(pa), .wdata(pd),
		.we(pwe), .rd(prd), .gnt(pgnt), .hrd(phrd), .rdata(pspo), .ready(pready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] vaddr(input int vpn1, input int vpn0, input int off);
		return (32'(vpn1) << 22) | (32'(vpn0) << 12) | 32'(off);
	endfunction

	// initial memory contents away from the page tables
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return a ^ (a << 16) ^ 32'ha5c3_5a3c;
	endfunction

	task automatic add_case(input logic [1:0] m, input logic pg, input logic [31:0] v,
			input logic w, input logic [31:0] d, input logic [31:0] p, input logic pf,
			input logic af, input logic [15:0] cause);
		cases.push_back({m, pg, v, w, d, p, pf, af, cause});
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic run_case(input case_t c, input int num);
		int waited;
		int errs_before;
		logic got;
		logic translated;
		logic exp_gnt;
		logic exp_hrd;
		logic arb_bad;
		logic [31:0] wd;
		logic [31:0] got_pa;
		logic [31:0] got_data;
		logic got_pf;
		logic got_af;
		logic [15:0] got_cause;
		logic [31:0] exp_data;
		errs_before = errors;
		// the stressed pass stores other words so its writes show up too
		wd = c.wdata ^ {32{stress}};
		translated = c.paging && !c.mode[1];
		arb_bad = 1'b0;
		@(posedge clk);
		#5;
		mode = c.mode;
		paging = c.paging;
		// let the enabled flag follow the new mode
		repeat (3) @(posedge clk);
		#5;
		va = c.va;
		vd = wd;
		vwe = c.wr;
		vrd = !c.wr;
		vreq = 1'b1;
		waited = 0;
		got = 1'b0;
		while (!got && waited < 200) begin
			@(negedge clk);
			// translated accesses never stall the processor, bypass shows the bus
			exp_gnt = translated ? 1'b1 : pgnt;
			exp_hrd = translated ? 1'b0 : phrd;
			if (!arb_bad && (vgnt !== exp_gnt || vhrd !== exp_hrd)) begin
				arb_bad = 1'b1;
				compare("vgnt", 32'(exp_gnt), 32'(vgnt));
				compare("vhrd", 32'(exp_hrd), 32'(vhrd));
			end
			// a bypass transfer needs the grant as well as ready
			if (vready && exp_gnt) begin
				got = 1'b1;
				got_pa = pa;
				got_data = vspo;
				got_pf = pagefault;
				got_af = accessfault;
				got_cause = err_code;
			end
			waited++;
		end
		@(posedge clk);
		#5;
		vreq = 1'b0;
		vwe = 1'b0;
		vrd = 1'b0;
		if (!got) begin
			$display("test %0d: no vready within 200 cycles", num);
			hung = 1'b1;
			run++;
			failed++;
		end else begin
			compare("pagefault", 32'(c.pf), 32'(got_pf));
			compare("accessfault", 32'(c.af), 32'(got_af));
			if (c.pf || c.af) begin
				compare("err_code", 32'(c.cause), 32'(got_cause));
			end else begin
				compare("pa", c.pa, got_pa);
				if (c.wr) begin
					shadow[c.pa] = wd;
				end else begin
					exp_data = shadow.exists(c.pa) ? shadow[c.pa] : fill_word(c.pa);
					compare("vspo", exp_data, got_data);
				end
			end
			run++;
			if (errors != errs_before) begin
				failed++;
			end
			$display("test %0d stress %0d: %s", num, stress,
				errors == errs_before ? "ok" : "failed");
		end
	endtask

	initial begin
		rst = 1'b1;
		stress = 1'b0;
		mode = 2'b11;
		paging = 1'b0;
		root_ppn = 22'd1;
		vreq = 1'b0;
		va = 32'h0;
		vd = 32'h0;
		vwe = 1'b0;
		vrd = 1'b0;
		errors = 0;
		failed = 0;
		run = 0;
		hung = 1'b0;

		// bypass, paging off then machine mode
		add_case(2'b01, 1'b0, 32'h8004, 1'b1, 32'hdead_beef, 32'h8004, 0, 0, 0);
		add_case(2'b11, 1'b1, 32'h8004, 1'b0, 32'h0, 32'h8004, 0, 0, 0);
		// supervisor translation through page 4
		add_case(2'b01, 1'b1, vaddr(0, 0, 'h10), 1'b0, 32'h0, 32'h4010, 0, 0, 0);
		add_case(2'b01, 1'b1, vaddr(0, 0, 'h20), 1'b1, 32'h1234_5678, 32'h4020, 0, 0, 0);
		add_case(2'b01, 1'b1, vaddr(0, 0, 'h20), 1'b0, 32'h0, 32'h4020, 0, 0, 0);
		// read-only page, store faults and memory keeps its word
		add_case(2'b01, 1'b1, vaddr(0, 1, 'h30), 1'b1, 32'hcafe_f00d, 0, 1, 0, `CAUSE_STORE_PAGE);
		add_case(2'b11, 1'b1, 32'h5030, 1'b0, 32'h0, 32'h5030, 0, 0, 0);
		add_case(2'b01, 1'b1, vaddr(0, 1, 'h30), 1'b0, 32'h0, 32'h5030, 0, 0, 0);
		// invalid and malformed entries
		add_case(2'b01, 1'b1, vaddr(1, 0, 0), 1'b0, 32'h0, 0, 1, 0, `CAUSE_LOAD_PAGE);
		add_case(2'b01, 1'b1, vaddr(1, 0, 0), 1'b1, 32'h1, 0, 1, 0, `CAUSE_STORE_PAGE);
		add_case(2'b01, 1'b1, vaddr(0, 2, 0), 1'b0, 32'h0, 0, 1, 0, `CAUSE_LOAD_PAGE);
		add_case(2'b01, 1'b1, vaddr(0, 3, 0), 1'b0, 32'h0, 0, 1, 0, `CAUSE_LOAD_PAGE);
		add_case(2'b01, 1'b1, vaddr(3, 0, 0), 1'b1, 32'h2, 0, 1, 0, `CAUSE_STORE_PAGE);
		add_case(2'b01, 1'b1, vaddr(0, 4, 0), 1'b0, 32'h0, 0, 1, 0, `CAUSE_LOAD_PAGE);
		// superpage leaf at level 1
		add_case(2'b01, 1'b1, vaddr(2, 0, 0), 1'b0, 32'h0, 0, 0, 1, `CAUSE_LOAD_ACCESS);
		add_case(2'b01, 1'b1, vaddr(2, 0, 0), 1'b1, 32'h3, 0, 0, 1, `CAUSE_STORE_ACCESS);
		// user mode needs U
		add_case(2'b00, 1'b1, vaddr(0, 0, 'h10), 1'b0, 32'h0, 0, 1, 0, `CAUSE_LOAD_PAGE);
		add_case(2'b00, 1'b1, vaddr(0, 5, 'h44), 1'b0, 32'h0, 32'h6044, 0, 0, 0);

		repeat (16) @(posedge clk);
		#5;
		rst = 1'b0;

		// second pass repeats everything under grant stalls and hold pulses
		for (int pass = 0; pass < 2 && !hung; pass++) begin
			stress = pass[0];
			foreach (cases[i]) begin
				if (!hung) begin
					run_case(cases[i], i);
				end
			end
		end

		$display("tests %0d, failed %0d, errors %0d", run, failed, errors);
		if (errors == 0 && !hung) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/sv32_pkg.sv
logic/mem_bus_if.sv
logic/sv32_walker.sv
logic/sv32_mmu_core.sv
logic/mmu_top.sv
testbench/tb_phys_mem.sv
testbench/tb_mmu_top.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = tb_mmu_top
FILELIST = files.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | awk '{ print } /^PASS: all tests$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
